/* decode_params.svh */
// ----------------------------------------
// Sizes of the TinyRV1 decode-issue stage
// Register address width follows NUM_REGS
// ----------------------------------------
`ifndef DECODE_PARAMS_SVH
`define DECODE_PARAMS_SVH

// Data and instruction word width
`define XLEN 32
// Architectural registers, x0 included
`define NUM_REGS 32
// Width of the in-flight sequence number
`define SEQ_BITS 8
// Execute pipes behind the router
`define NUM_PIPES 2

`endif

/* rv_isa_pkg.sv */
// ----------------------------------------
// TinyRV1 encodings and instruction views
// Only the eight TinyRV1 ops are named
// ----------------------------------------
package rv_isa_pkg;

  // Major opcodes
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_load   = 7'b0000011;
  localparam logic [6:0] opc_store  = 7'b0100011;
  localparam logic [6:0] opc_jal    = 7'b1101111;
  localparam logic [6:0] opc_jalr   = 7'b1100111;
  localparam logic [6:0] opc_branch = 7'b1100011;

  // ----------------------------------------
  // Instruction formats
  // ----------------------------------------

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  // Also the B layout, imm bits are reshuffled in imm_gen
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic [19:0] imm;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } j_fmt_t;

  // One fetched word, four views
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    j_fmt_t j;
  } rv_inst_u;

  // Micro-ops seen by the execute pipes
  typedef enum logic [3:0] {
    uop_add, uop_addi, uop_mul, uop_lw, uop_sw, uop_jal, uop_jr, uop_bne, uop_invalid
  } rv_uop_e;

  // Immediate formats
  typedef enum logic [1:0] {
    imm_i, imm_s, imm_b, imm_j
  } rv_imm_e;

endpackage

/* rv_stage_pkg.sv */
// ----------------------------------------
// Messages between fetch, decode-issue,
// the execute pipes and completion
// ----------------------------------------
`include "decode_params.svh"

package rv_stage_pkg;

  // Fetch to decode
  typedef struct packed {
    logic [`XLEN-1:0]     pc;
    logic [`XLEN-1:0]     inst;
    logic [`SEQ_BITS-1:0] seq_num;
  } fetch_msg_t;

  // Decode to execute, shared by all pipes
  typedef struct packed {
    logic [`XLEN-1:0]              pc;
    logic [`XLEN-1:0]              op1;
    logic [`XLEN-1:0]              op2;
    rv_isa_pkg::rv_uop_e           uop;
    logic [$clog2(`NUM_REGS)-1:0]  waddr;
    logic [`SEQ_BITS-1:0]          seq_num;
  } issue_msg_t;

  // Writeback notice from the pipes
  typedef struct packed {
    logic                          wen;
    logic [$clog2(`NUM_REGS)-1:0]  waddr;
    logic [`XLEN-1:0]              wdata;
    logic [`SEQ_BITS-1:0]          seq_num;
  } complete_msg_t;

endpackage

/* inst_decoder.sv */
// ----------------------------------------
// TinyRV1 decode, purely combinational
// Unknown encodings give uop_invalid
// ----------------------------------------
`timescale 1ns/10ps

module inst_decoder (
  input  rv_isa_pkg::rv_inst_u inst,
  output rv_isa_pkg::rv_uop_e  uop,
  output logic [4:0]           raddr0,
  output logic [4:0]           raddr1,
  output logic [4:0]           waddr,
  output logic                 wen,
  output rv_isa_pkg::rv_imm_e  imm_sel,
  output logic                 op2_sel
);
  import rv_isa_pkg::*;

  always_comb begin
    // Unused sources stay at x0, which never stalls
    uop     = uop_invalid;
    raddr0  = 5'd0;
    raddr1  = 5'd0;
    waddr   = 5'd0;
    wen     = 1'b0;
    imm_sel = imm_i;
    op2_sel = 1'b0;

    case (inst.r.opcode)
      opc_op: begin
        if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0000000) begin
          uop = uop_add;
        end else if (inst.r.funct3 == 3'b000 && inst.r.funct7 == 7'b0000001) begin
          uop = uop_mul;
        end
        if (uop != uop_invalid) begin
          raddr0 = inst.r.rs1;
          raddr1 = inst.r.rs2;
          waddr  = inst.r.rd;
          wen    = 1'b1;
        end
      end
      opc_op_imm, opc_load: begin
        if (inst.i.funct3 == ((inst.i.opcode == opc_load) ? 3'b010 : 3'b000)) begin
          uop     = (inst.i.opcode == opc_load) ? uop_lw : uop_addi;
          raddr0  = inst.i.rs1;
          waddr   = inst.i.rd;
          wen     = 1'b1;
          op2_sel = 1'b1;
        end
      end
      opc_store: begin
        // Store data still read, so its producer must finish
        if (inst.s.funct3 == 3'b010) begin
          uop     = uop_sw;
          raddr0  = inst.s.rs1;
          raddr1  = inst.s.rs2;
          imm_sel = imm_s;
          op2_sel = 1'b1;
        end
      end
      opc_jal: begin
        // No source, op1 reads x0
        uop     = uop_jal;
        waddr   = inst.j.rd;
        wen     = 1'b1;
        imm_sel = imm_j;
        op2_sel = 1'b1;
      end
      opc_jalr: begin
        // jr is jalr with rd at x0, nothing written back
        if (inst.i.funct3 == 3'b000) begin
          uop     = uop_jr;
          raddr0  = inst.i.rs1;
          op2_sel = 1'b1;
        end
      end
      opc_branch: begin
        if (inst.s.funct3 == 3'b001) begin
          uop     = uop_bne;
          raddr0  = inst.s.rs1;
          raddr1  = inst.s.rs2;
          imm_sel = imm_b;
        end
      end
      default: begin
        uop = uop_invalid;
      end
    endcase
  end

endmodule

/* imm_gen.sv */
// ----------------------------------------
// Sign-extended immediate, I/S/B/J only
// ----------------------------------------
`timescale 1ns/10ps

module imm_gen (
  input  rv_isa_pkg::rv_inst_u inst,
  input  rv_isa_pkg::rv_imm_e  imm_sel,
  output logic [31:0]          imm
);
  import rv_isa_pkg::*;

  always_comb begin
    case (imm_sel)
      imm_s: imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
      // B reuses the S fields, bit 0 is implied zero
      imm_b: imm = {{19{inst.s.imm_hi[6]}}, inst.s.imm_hi[6], inst.s.imm_lo[0],
                    inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
      // J bits 20, 10:1, 11, 19:12 from the top down
      imm_j: imm = {{11{inst.j.imm[19]}}, inst.j.imm[19], inst.j.imm[7:0],
                    inst.j.imm[8], inst.j.imm[18:9], 1'b0};
      default: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
    endcase
  end

endmodule

/* scoreboard_regfile.sv */
// ----------------------------------------
// 2R1W register file with pending bits
// Reads are combinational, no bypass
// x0 reads zero and is never pending
// ----------------------------------------
`timescale 1ns/10ps
`include "decode_params.svh"

module scoreboard_regfile (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [$clog2(`NUM_REGS)-1:0] raddr0,
  input  logic [$clog2(`NUM_REGS)-1:0] raddr1,
  input  logic [$clog2(`NUM_REGS)-1:0] waddr,
  input  logic [`XLEN-1:0]             wdata,
  input  logic                         wen,
  input  logic [$clog2(`NUM_REGS)-1:0] set_addr,
  input  logic                         set_en,
  output logic [`XLEN-1:0]             rdata0,
  output logic [`XLEN-1:0]             rdata1,
  output logic                         pend0,
  output logic                         pend1,
  output logic                         pend_dst
);

  logic [`XLEN-1:0]    regs [`NUM_REGS];
  logic [`NUM_REGS-1:0] pending;

  // Data array, x0 never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int r = 0; r < `NUM_REGS; r++) begin
        regs[r] <= '0;
      end
    end else if (wen && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // Scoreboard
  always_ff @(posedge clk) begin
    if (rst) begin
      pending <= '0;
    end else begin
      if (wen) begin
        pending[waddr] <= 1'b0;
      end
      // A new issue wins over an older completion
      if (set_en) begin
        pending[set_addr] <= 1'b1;
      end
      pending[0] <= 1'b0;
    end
  end

  assign rdata0   = (raddr0 == '0) ? '0 : regs[raddr0];
  assign rdata1   = (raddr1 == '0) ? '0 : regs[raddr1];
  assign pend0    = pending[raddr0];
  assign pend1    = pending[raddr1];
  assign pend_dst = pending[set_addr];

endmodule

/* issue_router.sv */
// ----------------------------------------
// Pipe select by micro-op
// Pipe 1 takes lw/sw, pipe 0 the rest
// ----------------------------------------
`timescale 1ns/10ps
`include "decode_params.svh"

module issue_router (
  input  rv_isa_pkg::rv_uop_e    uop,
  input  logic                   val,
  input  logic [`NUM_PIPES-1:0]  issue_rdy,
  output logic [`NUM_PIPES-1:0]  issue_val,
  output logic                   issue_xfer
);
  import rv_isa_pkg::*;

  localparam int PIPE_BITS = $clog2(`NUM_PIPES);

  logic [PIPE_BITS-1:0] pipe_sel;

  // Memory ops to the load/store pipe
  assign pipe_sel = (uop == uop_lw || uop == uop_sw) ? PIPE_BITS'(1) : PIPE_BITS'(0);

  // One-hot valid, all low when idle
  always_comb begin
    issue_val = '0;
    if (val) begin
      issue_val[pipe_sel] = 1'b1;
    end
  end

  assign issue_xfer = val & issue_rdy[pipe_sel];

endmodule

/* decode_issue_unit.sv */
// ----------------------------------------
// TinyRV1 in-order single-issue stage
// No forwarding, stalls on any pending reg
// issue_msg is shared by all pipes
// ----------------------------------------
`timescale 1ns/10ps
`include "decode_params.svh"

module decode_issue_unit (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        fetch_val,
  output logic                        fetch_rdy,
  input  rv_stage_pkg::fetch_msg_t    fetch_msg,
  output logic [`NUM_PIPES-1:0]       issue_val,
  input  logic [`NUM_PIPES-1:0]       issue_rdy,
  output rv_stage_pkg::issue_msg_t    issue_msg,
  input  logic                        complete_val,
  input  rv_stage_pkg::complete_msg_t complete_msg
);
  import rv_isa_pkg::*;
  import rv_stage_pkg::*;

  // ----------------------------------------
  // Fetch register
  // ----------------------------------------

  logic       fetch_q_val;
  fetch_msg_t fetch_q;
  logic       fetch_xfer;
  logic       issue_xfer;

  assign fetch_xfer = fetch_val & fetch_rdy;
  // Empty, or draining this cycle
  assign fetch_rdy  = ~fetch_q_val | issue_xfer;

  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_q_val <= 1'b0;
    end else if (fetch_xfer) begin
      fetch_q_val <= 1'b1;
    end else if (issue_xfer) begin
      fetch_q_val <= 1'b0;
    end
  end

  // Payload only moves on accept
  always_ff @(posedge clk) begin
    if (fetch_xfer) begin
      fetch_q <= fetch_msg;
    end
  end

  // ----------------------------------------
  // Decode, immediate, scoreboard
  // ----------------------------------------

  rv_uop_e     dec_uop;
  logic [4:0]  dec_raddr0;
  logic [4:0]  dec_raddr1;
  logic [4:0]  dec_waddr;
  logic        dec_wen;
  rv_imm_e     dec_imm_sel;
  logic        dec_op2_sel;
  logic [31:0] imm;
  logic [31:0] rdata0;
  logic [31:0] rdata1;
  logic        pend0;
  logic        pend1;
  logic        pend_dst;
  logic        stall;

  inst_decoder u_inst_decoder (
    .inst    (fetch_q.inst),
    .uop     (dec_uop),
    .raddr0  (dec_raddr0),
    .raddr1  (dec_raddr1),
    .waddr   (dec_waddr),
    .wen     (dec_wen),
    .imm_sel (dec_imm_sel),
    .op2_sel (dec_op2_sel)
  );

  imm_gen u_imm_gen (
    .inst    (fetch_q.inst),
    .imm_sel (dec_imm_sel),
    .imm     (imm)
  );

  scoreboard_regfile u_scoreboard_regfile (
    .clk      (clk),
    .rst      (rst),
    .raddr0   (dec_raddr0),
    .raddr1   (dec_raddr1),
    .waddr    (complete_msg.waddr),
    .wdata    (complete_msg.wdata),
    .wen      (complete_val & complete_msg.wen),
    .set_addr (dec_waddr),
    .set_en   (dec_wen & issue_xfer),
    .rdata0   (rdata0),
    .rdata1   (rdata1),
    .pend0    (pend0),
    .pend1    (pend1),
    .pend_dst (pend_dst)
  );

  // RAW on sources, WAW on destination
  assign stall = pend0 | pend1 | pend_dst;

  // ----------------------------------------
  // Routing and issue message
  // ----------------------------------------

  issue_router u_issue_router (
    .uop        (dec_uop),
    .val        (fetch_q_val & ~stall),
    .issue_rdy  (issue_rdy),
    .issue_val  (issue_val),
    .issue_xfer (issue_xfer)
  );

  // op2 is the immediate for addi/lw/sw/jal/jr
  always_comb begin
    issue_msg.pc      = fetch_q.pc;
    issue_msg.op1     = rdata0;
    issue_msg.op2     = dec_op2_sel ? imm : rdata1;
    issue_msg.uop     = dec_uop;
    issue_msg.waddr   = dec_waddr;
    issue_msg.seq_num = fetch_q.seq_num;
  end

endmodule

/* tb_decode_issue.sv */
// ----------------------------------------
// Testbench for decode_issue_unit
// Stimulus and expected issues come from
// decode_issue_input.txt, run from the root
// ----------------------------------------
`timescale 1ns/10ps
`include "decode_params.svh"

module tb_decode_issue;
  import rv_isa_pkg::*;
  import rv_stage_pkg::*;

  localparam int TIMEOUT_CYCLES = 200;

  // One expected issue, pipe plus message
  typedef struct packed {
    logic       pipe;
    issue_msg_t msg;
  } expect_t;

  logic                  clk;
  logic                  rst;
  logic                  fetch_val;
  logic                  fetch_rdy;
  fetch_msg_t            fetch_msg;
  logic [`NUM_PIPES-1:0] issue_val;
  logic [`NUM_PIPES-1:0] issue_rdy;
  issue_msg_t            issue_msg;
  logic                  complete_val;
  complete_msg_t         complete_msg;

  expect_t     exp_q[$];
  logic [31:0] rng_state = 32'd62;

  decode_issue_unit u_decode_issue_unit (
    .clk          (clk),
    .rst          (rst),
    .fetch_val    (fetch_val),
    .fetch_rdy    (fetch_rdy),
    .fetch_msg    (fetch_msg),
    .issue_val    (issue_val),
    .issue_rdy    (issue_rdy),
    .issue_msg    (issue_msg),
    .complete_val (complete_val),
    .complete_msg (complete_msg)
  );

  // 8 ns clock
  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic string issue_text(input issue_msg_t m);
    return $sformatf("pc=%h op1=%h op2=%h uop=%0d waddr=%0d seq=%0d",
                     m.pc, m.op1, m.op2, m.uop, m.waddr, m.seq_num);
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "stopped at first failure");
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: %s expected %b got %b", $time, name, exp, got));
    end
  endtask

  task automatic check_issue(input issue_msg_t got, input issue_msg_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Error at %0t: issue_msg expected %s got %s",
                          $time, issue_text(exp), issue_text(got)));
    end
  endtask

  // Offer one fetch, hold until accepted
  task automatic fetch_inst(input fetch_msg_t msg, input expect_t exp);
    int waited;
    waited = 0;
    @(posedge clk);
    fetch_val <= 1'b1;
    fetch_msg <= msg;
    exp_q.push_back(exp);
    @(negedge clk);
    while (!fetch_rdy) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("Timeout: fetch_rdy stayed low, instruction never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    fetch_val <= 1'b0;
  endtask

  // Single-cycle completion pulse
  task automatic complete_reg(input complete_msg_t msg);
    @(posedge clk);
    complete_val <= 1'b1;
    complete_msg <= msg;
    @(posedge clk);
    complete_val <= 1'b0;
  endtask

  // Stalled instruction, nothing offered
  task automatic hold_no_issue(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      check_bit("issue_val[0]", issue_val[0], 1'b0);
      check_bit("issue_val[1]", issue_val[1], 1'b0);
      check_bit("fetch_rdy", fetch_rdy, 1'b0);
    end
  endtask

  task automatic wait_drained();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        abort_run("Timeout: expected instructions were never issued");
      end
      @(negedge clk);
    end
  endtask

  // ----------------------------------------
  // Issue side, random back-pressure
  // ----------------------------------------

  always @(posedge clk) begin
    rng_state = lcg_step(rng_state);
    issue_rdy <= {rng_state[24], rng_state[16]};
  end

  // Issue monitor, pops on each transfer
  always @(negedge clk) begin : issue_monitor
    expect_t front;
    if (!rst && issue_val != '0) begin
      if (exp_q.size() == 0) begin
        abort_run("Unexpected issue: issue_val raised with no instruction pending");
      end else begin
        front = exp_q[0];
        check_bit("issue_val[0]", issue_val[0], front.pipe == 1'b0);
        check_bit("issue_val[1]", issue_val[1], front.pipe == 1'b1);
        check_issue(issue_msg, front.msg);
        // Full fetch register drains only on transfer
        check_bit("fetch_rdy", fetch_rdy, issue_rdy[front.pipe]);
        if (issue_rdy[front.pipe]) begin
          void'(exp_q.pop_front());
        end
      end
    end
  end

  // ----------------------------------------
  // Stimulus from the data file
  // ----------------------------------------

  initial begin : run_stimulus
    int            fd;
    int            n;
    int            seq;
    int            pipe;
    int            uop;
    int            waddr;
    int            wen;
    int            cycles;
    string         line;
    string         tag;
    logic [31:0]   pc;
    logic [31:0]   inst;
    logic [31:0]   op1;
    logic [31:0]   op2;
    logic [31:0]   wdata;
    fetch_msg_t    fmsg;
    expect_t       exp;
    complete_msg_t cmsg;

    rst          = 1'b1;
    fetch_val    = 1'b0;
    fetch_msg    = '0;
    issue_rdy    = '0;
    complete_val = 1'b0;
    complete_msg = '0;
    repeat (5) @(posedge clk);
    rst <= 1'b0;

    // Empty stage after reset
    @(negedge clk);
    check_bit("fetch_rdy", fetch_rdy, 1'b1);
    check_bit("issue_val[0]", issue_val[0], 1'b0);
    check_bit("issue_val[1]", issue_val[1], 1'b0);

    fd = $fopen("decode_issue_input.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open decode_issue_input.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      tag  = "";
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%s", tag);
      end
      if (n == 1 && tag == "F") begin
        n = $sscanf(line, "F %h %h %d %d %h %h %d %d",
                    pc, inst, seq, pipe, op1, op2, uop, waddr);
        if (n != 8) begin
          abort_run({"Malformed fetch line: ", line});
        end else begin
          fmsg.pc          = pc;
          fmsg.inst        = inst;
          fmsg.seq_num     = 8'(seq);
          // pc and seq_num pass straight through
          exp.pipe          = pipe[0];
          exp.msg.pc        = pc;
          exp.msg.op1       = op1;
          exp.msg.op2       = op2;
          exp.msg.uop       = rv_uop_e'(uop);
          exp.msg.waddr     = 5'(waddr);
          exp.msg.seq_num   = 8'(seq);
          fetch_inst(fmsg, exp);
        end
      end else if (n == 1 && tag == "C") begin
        n = $sscanf(line, "C %d %d %h %d", wen, waddr, wdata, seq);
        if (n != 4) begin
          abort_run({"Malformed completion line: ", line});
        end else begin
          cmsg.wen     = wen[0];
          cmsg.waddr   = 5'(waddr);
          cmsg.wdata   = wdata;
          cmsg.seq_num = 8'(seq);
          complete_reg(cmsg);
        end
      end else if (n == 1 && tag == "H") begin
        n = $sscanf(line, "H %d", cycles);
        if (n != 1) begin
          abort_run({"Malformed hazard line: ", line});
        end else begin
          hold_no_issue(cycles);
        end
      end else if (n == 1 && tag != "#") begin
        abort_run({"Unknown line in stimulus file: ", line});
      end
    end
    $fclose(fd);

    wait_drained();
    // A few idle cycles to catch a stray second issue
    repeat (4) @(negedge clk);
    $display("No errors");
    $finish;
  end

endmodule

/* decode_issue_input.txt */
# F pc inst seq pipe op1 op2 uop waddr = fetch plus expected issue; C wen waddr wdata seq
# H n = no issue for n cycles; uop add=0 addi=1 mul=2 lw=3 sw=4 jal=5 jr=6 bne=7; pc/inst/op/wdata hex
C 1 1 00000010 0
C 1 2 00000003 0
F 00000100 ffb08193 1 0 00000010 fffffffb 1 3  addi x3, x1, -5
F 00000104 00208233 2 0 00000010 00000003 0 4  add x4, x1, x2
F 00000108 00812283 3 1 00000003 00000008 3 5  lw x5, 8(x2)
F 0000010c fe112e23 4 1 00000003 fffffffc 4 0  sw x1, -4(x2)
F 00000110 00128333 5 0 0000abcd 00000010 0 6  add x6, x5, x1 waits on x5
H 4
C 1 5 0000abcd 3
C 1 0 deadbeef 9  write to x0 is dropped
F 00000114 00500393 6 0 00000000 00000005 1 7  addi x7, x0, 5
F 00000118 00208033 7 0 00000010 00000003 0 0  add x0, x1, x2
F 0000011c 00700413 8 0 00000000 00000007 1 8  addi x8, x0, 7
F 00000120 022104b3 9 0 00000003 00000003 2 9  mul x9, x2, x2
F 00000124 010000ef 10 0 00000000 00000010 5 1  jal x1, 16
F 00000128 fe011ce3 11 0 00000003 00000000 7 0  bne x2, x0, -8
F 0000012c 00010067 12 0 00000003 00000000 6 0  jr x2
F 00000130 00208533 13 0 00000128 00000003 0 10  add x10, x1, x2 waits on x1
H 3
C 1 1 00000128 10

/* sources.f */
+incdir+.
rv_isa_pkg.sv
rv_stage_pkg.sv
inst_decoder.sv
imm_gen.sv
scoreboard_regfile.sv
issue_router.sv
decode_issue_unit.sv
tb_decode_issue.sv

/* Bender.yml */
package:
  name: decode_issue

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - rv_stage_pkg.sv
      - inst_decoder.sv
      - imm_gen.sv
      - scoreboard_regfile.sv
      - issue_router.sv
      - decode_issue_unit.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_decode_issue.sv
